// File: common/vertex_pkg.sv
// Fixed-point type, vertex and triangle structs, 16.16 multiply and shared constants
package vertex_pkg;

    typedef logic signed [31:0] fixed_t; // Signed 16.16

    localparam fixed_t FIXED_ONE = 32'sh0001_0000;

    // Four matrix rows for each of the three vertices
    localparam int ELEMENT_COUNT = 12;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vec3_t;

    // Matrix row or transformed vertex
    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
        fixed_t w;
    } vec4_t;

    typedef struct packed {
        vec3_t      v0;
        vec3_t      v1;
        vec3_t      v2;
        logic [2:0] colour; // One bit per vertex
    } tri_in_t;

    typedef struct packed {
        vec4_t      v0;
        vec4_t      v1;
        vec4_t      v2;
        logic [2:0] colour;
    } tri_out_t;

    // Full signed product, then drop the extra 16 fraction bits and wrap to 32 bits
    function automatic fixed_t fixed_mul(input fixed_t a, input fixed_t b);
        logic signed [63:0] product;
        product = a * b;
        return fixed_t'(product >>> 16);
    endfunction

endpackage

// File: vertex_transform/vertex_fsm.sv
// Control FSM for triangle acceptance, element stepping and output hold under stall
`timescale 1ns/1ns

module vertex_fsm (
    input  logic clock,
    input  logic reset,
    input  logic tri_valid,
    input  logic stall_in,
    input  logic last,
    output logic start,
    output logic count_enable,
    output logic out_valid,
    output logic stall_out
);

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        HOLD
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (tri_valid) begin
                    next_state = COMPUTE;
                end
            end
            COMPUTE: begin
                if (last) begin
                    next_state = HOLD; // Final element is stored on this same edge
                end
            end
            HOLD: begin
                if (!stall_in) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // Accepting edge is the one where start is high
    assign start = (state == IDLE) && tri_valid;

    assign count_enable = (state == COMPUTE);
    assign out_valid    = (state == HOLD);
    assign stall_out    = (state != IDLE); // Busy from acceptance until the result is released

endmodule

// File: vertex_transform/element_counter.sv
// Element counter over the vertex and row pairs of one triangle
`timescale 1ns/1ns

module element_counter
    import vertex_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  logic       count_enable,
    output logic [1:0] vertex_index,
    output logic [1:0] row_index,
    output logic       last
);

    logic [3:0] count;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if (start) begin
            count <= '0;
        end else if (count_enable) begin
            if (last) begin
                count <= '0;
            end else begin
                count <= count + 4'd1;
            end
        end
    end

    // Four rows per vertex, so the row sits in the low bits and the vertex above it
    assign row_index    = count[1:0];
    assign vertex_index = count[3:2];
    assign last         = (count == 4'(ELEMENT_COUNT - 1));

endmodule

// File: vertex_transform/matrix_store.sv
// Four-row register file holding the transform matrix
`timescale 1ns/1ns

module matrix_store
    import vertex_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       mat_write,
    input  logic [1:0] mat_row,
    input  vec4_t      mat_data,
    input  logic [1:0] row_index,
    output vec4_t      row
);

    vec4_t rows [4];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 4; i++) begin
                rows[i] <= '0;
            end
        end else if (mat_write) begin
            rows[mat_row] <= mat_data;
        end
    end

    // Read port follows the counter without delay
    assign row = rows[row_index];

endmodule

// File: vertex_transform/vertex_dot.sv
// Input triangle capture and one row-by-vertex dot product per cycle
`timescale 1ns/1ns

module vertex_dot
    import vertex_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  tri_in_t    tri_data,
    input  logic [1:0] vertex_index,
    input  vec4_t      row,
    output fixed_t     dot,
    output logic [2:0] colour
);

    tri_in_t captured;
    vec3_t   vertex;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            captured <= '0;
        end else if (start) begin
            captured <= tri_data;
        end
    end

    always_comb begin
        case (vertex_index)
            2'd0:    vertex = captured.v0;
            2'd1:    vertex = captured.v1;
            default: vertex = captured.v2;
        endcase
    end

    // The input w is always one, so the last term is the row's translation part
    assign dot = fixed_mul(row.x, vertex.x)
               + fixed_mul(row.y, vertex.y)
               + fixed_mul(row.z, vertex.z)
               + fixed_mul(row.w, FIXED_ONE);

    assign colour = captured.colour;

endmodule

// File: vertex_transform/viewport_map.sv
// Viewport mapping of x and y and the output triangle register
`timescale 1ns/1ns

module viewport_map
    import vertex_pkg::*;
#(
    parameter int SCREEN_WIDTH  = 640,
    parameter int SCREEN_HEIGHT = 480
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       count_enable,
    input  logic [1:0] vertex_index,
    input  logic [1:0] row_index,
    input  fixed_t     dot,
    input  logic [2:0] colour,
    output tri_out_t   tri_result
);

    localparam fixed_t HALF_WIDTH  = fixed_t'(SCREEN_WIDTH / 2) << 16;
    localparam fixed_t HALF_HEIGHT = fixed_t'(SCREEN_HEIGHT / 2) << 16;

    fixed_t mapped;

    // Replaces one element of a vertex, row 0 is x through row 3 is w
    function automatic vec4_t set_element(input vec4_t v, input logic [1:0] index,
                                          input fixed_t value);
        vec4_t result;
        result = v;
        case (index)
            2'd0:    result.x = value;
            2'd1:    result.y = value;
            2'd2:    result.z = value;
            default: result.w = value;
        endcase
        return result;
    endfunction

    always_comb begin
        case (row_index)
            2'd0:    mapped = fixed_mul(dot, HALF_WIDTH) + HALF_WIDTH;
            2'd1:    mapped = fixed_mul(dot, HALF_HEIGHT) + HALF_HEIGHT;
            default: mapped = dot; // z and w pass straight through
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            tri_result <= '0;
        end else if (count_enable) begin
            case (vertex_index)
                2'd0:    tri_result.v0 <= set_element(tri_result.v0, row_index, mapped);
                2'd1:    tri_result.v1 <= set_element(tri_result.v1, row_index, mapped);
                default: tri_result.v2 <= set_element(tri_result.v2, row_index, mapped);
            endcase
            tri_result.colour <= colour;
        end
    end

endmodule

// File: source/vertex_top.sv
// Top level of the vertex transform stage connecting control, matrix, dot product and viewport
`timescale 1ns/1ns

module vertex_top
    import vertex_pkg::*;
#(
    parameter int SCREEN_WIDTH  = 640,
    parameter int SCREEN_HEIGHT = 480
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       mat_write,
    input  logic [1:0] mat_row,
    input  vec4_t      mat_data,
    input  logic       tri_valid,
    input  tri_in_t    tri_data,
    input  logic       stall_in,
    output tri_out_t   tri_result,
    output logic       out_valid,
    output logic       stall_out
);

    logic       start;
    logic       count_enable;
    logic       last;
    logic [1:0] vertex_index;
    logic [1:0] row_index;
    vec4_t      row;
    fixed_t     dot;
    logic [2:0] colour;

    vertex_fsm u_fsm (
        .clock        (clock),
        .reset        (reset),
        .tri_valid    (tri_valid),
        .stall_in     (stall_in),
        .last         (last),
        .start        (start),
        .count_enable (count_enable),
        .out_valid    (out_valid),
        .stall_out    (stall_out)
    );

    element_counter u_counter (
        .clock        (clock),
        .reset        (reset),
        .start        (start),
        .count_enable (count_enable),
        .vertex_index (vertex_index),
        .row_index    (row_index),
        .last         (last)
    );

    matrix_store u_matrix (
        .clock     (clock),
        .reset     (reset),
        .mat_write (mat_write),
        .mat_row   (mat_row),
        .mat_data  (mat_data),
        .row_index (row_index),
        .row       (row)
    );

    vertex_dot u_dot (
        .clock        (clock),
        .reset        (reset),
        .start        (start),
        .tri_data     (tri_data),
        .vertex_index (vertex_index),
        .row          (row),
        .dot          (dot),
        .colour       (colour)
    );

    viewport_map #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) u_viewport (
        .clock        (clock),
        .reset        (reset),
        .count_enable (count_enable),
        .vertex_index (vertex_index),
        .row_index    (row_index),
        .dot          (dot),
        .colour       (colour),
        .tri_result   (tri_result)
    );

endmodule

// File: sim/tb_vertex_top.sv
// Testbench for the vertex transform stage with reference model, checker and timeout
`timescale 1ns/1ns

module tb_vertex_top
    import vertex_pkg::*;
();

    localparam int SCREEN_WIDTH   = 640;
    localparam int SCREEN_HEIGHT  = 480;
    localparam int TRIANGLE_COUNT = 55; // Includes the pulse that must be ignored
    localparam int TIMEOUT_CYCLES = 40 * TRIANGLE_COUNT + 200;
    localparam fixed_t HALF_WIDTH  = fixed_t'(SCREEN_WIDTH / 2 * 65536);
    localparam fixed_t HALF_HEIGHT = fixed_t'(SCREEN_HEIGHT / 2 * 65536);

    logic       clock;
    logic       reset;
    logic       mat_write;
    logic [1:0] mat_row;
    vec4_t      mat_data;
    logic       tri_valid;
    tri_in_t    tri_data;
    logic       stall_in;
    tri_out_t   tri_result;
    logic       out_valid;
    logic       stall_out;

    integer     seed;
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    int         results_seen = 0;
    int         sent_count = 0;
    vec4_t      model_matrix [4];
    vec4_t      new_matrix [4];
    tri_in_t    tri_next;
    tri_out_t   expected_q [$];
    int         accept_q [$];
    tri_out_t   expected;
    logic       was_valid = 1'b0;
    logic       was_stall_in = 1'b0;

    vertex_top u_dut (.*);

    always #5 clock = ~clock;

    function automatic fixed_t q16_product(input fixed_t a, input fixed_t b);
        logic signed [63:0] full;
        full = 64'(a) * 64'(b);
        return full[47:16];
    endfunction

    // Each vertex with w of one times each matrix row, then x and y onto the screen
    function automatic tri_out_t transform_triangle(input tri_in_t t, input vec4_t m [4]);
        vec3_t    v [3];
        fixed_t   d [4];
        vec4_t    mapped [3];
        tri_out_t result;
        v = '{t.v0, t.v1, t.v2};
        for (int i = 0; i < 3; i++) begin
            for (int r = 0; r < 4; r++) begin
                d[r] = q16_product(m[r].x, v[i].x) + q16_product(m[r].y, v[i].y)
                     + q16_product(m[r].z, v[i].z) + m[r].w;
            end
            mapped[i] = '{q16_product(d[0], HALF_WIDTH) + HALF_WIDTH,
                          q16_product(d[1], HALF_HEIGHT) + HALF_HEIGHT, d[2], d[3]};
        end
        result = '{mapped[0], mapped[1], mapped[2], t.colour};
        return result;
    endfunction

    function automatic fixed_t rand_fixed();
        return fixed_t'($random(seed) % 262144); // Within plus or minus 4.0
    endfunction

    function automatic vec4_t rand_vec4();
        vec4_t v;
        v = '{rand_fixed(), rand_fixed(), rand_fixed(), rand_fixed()};
        return v;
    endfunction

    function automatic tri_in_t rand_triangle();
        tri_in_t t;
        t.v0     = '{rand_fixed(), rand_fixed(), rand_fixed()};
        t.v1     = '{rand_fixed(), rand_fixed(), rand_fixed()};
        t.v2     = '{rand_fixed(), rand_fixed(), rand_fixed()};
        t.colour = 3'($random(seed));
        return t;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic compare_triangle(input string what, input tri_out_t got,
                                    input tri_out_t want);
        for (int i = 0; i < ELEMENT_COUNT; i++) begin
            check_value($sformatf("%s word %0d", what, i),
                        got[3 + 32 * i +: 32], want[3 + 32 * i +: 32]);
        end
        check_value({what, " colour"}, 32'(got.colour), 32'(want.colour));
    endtask

    task automatic wait_idle();
        @(negedge clock);
        while (stall_out) @(negedge clock);
    endtask

    task automatic wait_result();
        @(negedge clock);
        while (!out_valid) @(negedge clock);
    endtask

    task automatic write_row(input int r, input vec4_t data);
        @(posedge clock);
        mat_write <= 1'b1;
        mat_row   <= 2'(r);
        mat_data  <= data;
        @(posedge clock);
        mat_write <= 1'b0;
    endtask

    task automatic load_matrix(input vec4_t m [4]);
        wait_idle();
        for (int r = 0; r < 4; r++) begin
            write_row(r, m[r]);
        end
    endtask

    task automatic send_triangle(input tri_in_t t);
        wait_idle();
        @(posedge clock);
        tri_valid <= 1'b1;
        tri_data  <= t;
        @(posedge clock); // Accepting edge, the stage was idle
        tri_valid <= 1'b0;
        sent_count++;
    endtask

    // Follows matrix writes and accepted triangles as the DUT sees them at each edge
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (reset && mat_write) begin
            model_matrix[mat_row] = mat_data;
        end
        if (reset && tri_valid && !stall_out) begin
            expected_q.push_back(transform_triangle(tri_data, model_matrix));
            accept_q.push_back(cycles);
        end
    end

    always @(negedge clock) begin
        if (reset) begin
            if (out_valid && !was_valid) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("%0t ns: out_valid rose with no accepted triangle pending", $time);
                end else begin
                    expected = expected_q.pop_front();
                    if (cycles - accept_q[0] != 12) begin
                        errors++;
                        $display("%0t ns: out_valid rose %0d cycles after acceptance, not 12",
                                 $time, cycles - accept_q[0]);
                    end
                    void'(accept_q.pop_front());
                    compare_triangle("result", tri_result, expected);
                    results_seen++;
                end
            end else if (out_valid) begin
                compare_triangle("held result", tri_result, expected);
            end
            if (was_valid) begin
                // Stall in the last cycle keeps the result, a release drops it
                check_value("out_valid after stall_in", 32'(out_valid), 32'(was_stall_in));
                check_value("stall_out after stall_in", 32'(stall_out), 32'(was_stall_in));
            end
            if (!out_valid && accept_q.size() > 0 && cycles - accept_q[0] > 12) begin
                errors++;
                $display("%0t ns: out_valid did not come 12 cycles after acceptance", $time);
                void'(accept_q.pop_front());
                void'(expected_q.pop_front());
            end
            was_valid    = out_valid;
            was_stall_in = stall_in;
        end
    end

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clock     = 1'b0;
        reset     = 1'b0;
        mat_write = 1'b0;
        mat_row   = 2'd0;
        mat_data  = '0;
        tri_valid = 1'b0;
        tri_data  = '0;
        stall_in  = 1'b0;
        seed      = 24;
        for (int r = 0; r < 4; r++) begin
            model_matrix[r] = '0;
        end
        repeat (8) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        check_value("out_valid after reset", 32'(out_valid), 0);
        check_value("stall_out after reset", 32'(stall_out), 0);

        // Identity matrix puts the origin at the screen centre
        new_matrix = '{'{FIXED_ONE, 0, 0, 0}, '{0, FIXED_ONE, 0, 0},
                       '{0, 0, FIXED_ONE, 0}, '{0, 0, 0, FIXED_ONE}};
        load_matrix(new_matrix);
        send_triangle('0);
        wait_result();
        check_value("centre x", tri_result.v0.x, HALF_WIDTH);
        check_value("centre y", tri_result.v0.y, HALF_HEIGHT);

        repeat (40) begin
            for (int r = 0; r < 4; r++) begin
                new_matrix[r] = rand_vec4();
            end
            load_matrix(new_matrix);
            send_triangle(rand_triangle());
        end

        repeat (8) begin
            wait_idle();
            @(posedge clock);
            stall_in <= 1'b1;
            send_triangle(rand_triangle());
            wait_result();
            repeat (1 + $unsigned($random(seed)) % 12) @(posedge clock);
            stall_in <= 1'b0;
        end

        send_triangle(rand_triangle());
        repeat (4) @(posedge clock);
        tri_valid <= 1'b1; // Arrives mid computation and must be dropped
        tri_data  <= rand_triangle();
        @(posedge clock);
        tri_valid <= 1'b0;
        send_triangle(rand_triangle());

        tri_next = rand_triangle();
        tri_next.colour = 3'b101;
        send_triangle(tri_next);
        wait_idle();
        write_row(2, rand_vec4());
        send_triangle(tri_next);
        wait_idle();
        write_row(0, rand_vec4());
        tri_next.colour = 3'b010;
        send_triangle(tri_next);
        wait_idle();

        repeat (4) @(posedge clock);
        check_value("result count", results_seen, sent_count);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
common/vertex_pkg.sv
vertex_transform/vertex_fsm.sv
vertex_transform/element_counter.sv
vertex_transform/matrix_store.sv
vertex_transform/vertex_dot.sv
vertex_transform/viewport_map.sv
source/vertex_top.sv
sim/tb_vertex_top.sv

// File: Makefile
SIM      = verilator
TOP      = tb_vertex_top
FILELIST = vlog.f
FLAGS    = --binary --timing -j 0 --top-module $(TOP)
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
